// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_load_unit
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/load_checker.sv ====
// ----------------------------------------------------------------------
// scoreboard of the load unit, records granted loads by memory id and
// compares every retired result with the value the memory rule predicts
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module load_checker #(
  parameter int unsigned NR_ENTRIES = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  input  logic [load_pkg::TRANS_ID_W-1:0]      trans_id_i,
  input  logic [load_pkg::ADDR_W-1:0]          vaddr_i,
  input  load_pkg::load_op_u                   op_i,
  input  logic                                 valid_o,
  input  logic [load_pkg::TRANS_ID_W-1:0]      trans_id_o,
  input  logic [load_pkg::XLEN-1:0]            result_o,
  input  logic                                 mem_req_o,
  input  logic                                 mem_gnt_i,
  input  logic [load_pkg::ADDR_W-1:0]          mem_addr_o,
  input  logic [1:0]                           mem_size_o,
  input  logic [$clog2(NR_ENTRIES)-1:0]        mem_id_o,
  input  logic                                 mem_rvalid_i,
  input  logic [$clog2(NR_ENTRIES)-1:0]        mem_rid_i,
  output int unsigned                          error_count_o,
  output int unsigned                          outstanding_o,
  output int unsigned                          retired_o,
  output int unsigned                          dropped_o
);
  import load_pkg::*;

  logic [NR_ENTRIES-1:0] busy;
  logic [NR_ENTRIES-1:0] flushed;
  logic [ADDR_W-1:0]     exp_addr [NR_ENTRIES];
  load_op_e              exp_op [NR_ENTRIES];
  logic [TRANS_ID_W-1:0] exp_tid [NR_ENTRIES];
  int unsigned           errors;
  int unsigned           retired;
  int unsigned           dropped;
  logic [XLEN-1:0]       expected;
  logic [ADDR_W-1:0]     exp_word;

  // memory byte k of a word is its low address byte plus k, odd bytes
  // get their top bit flipped so signed loads see both signs
  function automatic logic [XLEN-1:0] predict(input logic [ADDR_W-1:0] addr,
                                              input load_op_e op);
    logic [7:0]      mem_bytes [8];
    logic [XLEN-1:0] val;
    logic [7:0]      base;
    int              nbytes;
    int              off;
    logic            signed_op;
    base = {addr[7:3], 3'b000};
    off  = int'(addr[2:0]);
    for (int k = 0; k < 8; k++) begin
      mem_bytes[k] = base + 8'(k);
      if (k % 2 == 1) begin
        mem_bytes[k] = mem_bytes[k] ^ 8'h80;
      end
    end
    case (op)
      LB, LBU: nbytes = 1;
      LH, LHU: nbytes = 2;
      LW, LWU: nbytes = 4;
      default: nbytes = 8;
    endcase
    signed_op = (op == LB) || (op == LH) || (op == LW);
    val = '0;
    for (int k = 0; k < nbytes; k++) begin
      val[k*8 +: 8] = mem_bytes[off + k];
    end
    // replicate the top loaded bit over the rest of the word
    if (signed_op && nbytes < 8 && val[nbytes*8-1]) begin
      for (int k = nbytes; k < 8; k++) begin
        val[k*8 +: 8] = 8'hff;
      end
    end
    return val;
  endfunction

  // memory size code of each load: byte 0, half 1, word 2, double 3
  function automatic logic [1:0] size_code(input load_op_e op);
    case (op)
      LB, LBU: return 2'd0;
      LH, LHU: return 2'd1;
      LW, LWU: return 2'd2;
      default: return 2'd3;
    endcase
  endfunction

  // outputs are settled half a cycle after the drive edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      busy    = '0;
      flushed = '0;
      errors  = 0;
      retired = 0;
      dropped = 0;
    end else begin
      if (&busy && mem_req_o) begin
        $display("memory request raised at %0t while every slot is busy", $time);
        errors++;
      end
      // a raised request carries the word address and size of the held input
      if (mem_req_o) begin
        exp_word = vaddr_i & 32'hffff_fff8;
        if (mem_addr_o !== exp_word || mem_size_o !== size_code(op_i.code)) begin
          $display("Mismatch at %0t: request addr %h size %0d, expected addr %h size %0d",
                   $time, mem_addr_o, mem_size_o, exp_word, size_code(op_i.code));
          errors++;
        end
      end
      if (mem_rvalid_i) begin
        if (!busy[mem_rid_i]) begin
          $display("response at %0t for id %0d that has no load", $time, mem_rid_i);
          errors++;
        end else if (flushed[mem_rid_i]) begin
          if (valid_o) begin
            $display("Mismatch at %0t: flushed load id %0d raised valid_o",
                     $time, mem_rid_i);
            errors++;
          end
          dropped++;
        end else begin
          expected = predict(exp_addr[mem_rid_i], exp_op[mem_rid_i]);
          if (!valid_o || trans_id_o !== exp_tid[mem_rid_i] || result_o !== expected) begin
            $display("Mismatch at %0t: valid %0b tid %0d result %h, expected tid %0d result %h",
                     $time, valid_o, trans_id_o, result_o, exp_tid[mem_rid_i], expected);
            errors++;
          end
          retired++;
        end
        busy[mem_rid_i] = 1'b0;
      end else if (valid_o) begin
        $display("Mismatch at %0t: valid_o without a memory response", $time);
        errors++;
      end
      // loads in flight lose their result, one booked now inherits the flush
      if (flush_i) begin
        flushed = '1;
      end
      if (mem_req_o && mem_gnt_i) begin
        if (busy[mem_id_o]) begin
          $display("request id %0d granted at %0t while still in flight", mem_id_o, $time);
          errors++;
        end
        busy[mem_id_o]     = 1'b1;
        flushed[mem_id_o]  = flush_i;
        exp_addr[mem_id_o] = vaddr_i;
        exp_op[mem_id_o]   = op_i.code;
        exp_tid[mem_id_o]  = trans_id_i;
      end
    end
  end

  assign error_count_o = errors;
  assign outstanding_o = $countones(busy);
  assign retired_o     = retired;
  assign dropped_o     = dropped;

endmodule

// ==== dv/load_unit_props.sv ====
// ----------------------------------------------------------------------
// concurrent checks on the memory handshake of the load unit
// bound into every load_unit instance of the simulation
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module load_unit_props #(
  parameter int unsigned NR_ENTRIES = 4
) (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input logic                                  mem_req_o,
  input logic                                  mem_gnt_i,
  input logic [load_pkg::ADDR_W-1:0]           mem_addr_o,
  input logic [1:0]                            mem_size_o,
  input logic [$clog2(NR_ENTRIES)-1:0]         mem_id_o,
  input logic                                  pop_ld_o,
  input logic                                  mem_rvalid_i,
  input logic [$clog2(NR_ENTRIES)-1:0]         mem_rid_i
);

  // ids that the memory has accepted and not yet answered
  logic [NR_ENTRIES-1:0] busy_d, busy_q;

  always_comb begin
    busy_d = busy_q;
    if (mem_rvalid_i) begin
      busy_d[mem_rid_i] = 1'b0;
    end
    if (mem_req_o && mem_gnt_i) begin
      busy_d[mem_id_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  // a waiting request keeps every field until the grant
  held_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_addr_o) &&
                                   $stable(mem_size_o) && $stable(mem_id_o)))
    else $error("request changed or dropped before its grant");

  // the memory may only answer ids that were granted
  rid_in_flight : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |-> busy_q[mem_rid_i])
    else $error("response id %0d names no outstanding load", mem_rid_i);

  pop_with_grant : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_ld_o |-> (mem_req_o && mem_gnt_i))
    else $error("input popped without a granted request");

endmodule

bind load_unit load_unit_props #(
  .NR_ENTRIES (NR_ENTRIES)
) props_inst (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .mem_req_o    (mem_req_o),
  .mem_gnt_i    (mem_gnt_i),
  .mem_addr_o   (mem_addr_o),
  .mem_size_o   (mem_size_o),
  .mem_id_o     (mem_id_o),
  .pop_ld_o     (pop_ld_o),
  .mem_rvalid_i (mem_rvalid_i),
  .mem_rid_i    (mem_rid_i)
);

// ==== dv/tb_load_unit.sv ====
// ----------------------------------------------------------------------
// top testbench of the load unit, runs a table of loads against a memory
// model with random grants and reordered responses
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_load_unit;
  import load_pkg::*;

  localparam int unsigned NR_ENTRIES  = 4;
  localparam int unsigned ID_W        = $clog2(NR_ENTRIES);
  localparam int unsigned N_LOADS     = 40;
  localparam int unsigned MAX_CYCLES  = N_LOADS * 40;
  localparam int          HOLD_CYCLES = 40;
  // row kinds: plain load, flush before the load, responses withheld
  localparam logic [1:0]  K_PLAIN = 2'd0;
  localparam logic [1:0]  K_FLUSH = 2'd1;
  localparam logic [1:0]  K_HOLD  = 2'd2;

  logic                  clk_i, rst_ni, flush_i, valid_i, pop_ld_o;
  logic [TRANS_ID_W-1:0] trans_id_i, trans_id_o;
  logic [ADDR_W-1:0]     vaddr_i, mem_addr_o;
  load_op_u              op_i;
  logic                  valid_o, mem_req_o, mem_gnt_i, mem_rvalid_i;
  logic [XLEN-1:0]       result_o, mem_rdata_i;
  logic [1:0]            mem_size_o;
  logic [ID_W-1:0]       mem_id_o, mem_rid_i;
  int unsigned           check_errors, outstanding, retired, dropped;

  // stimulus table
  logic [TRANS_ID_W-1:0] tbl_tid [N_LOADS];
  logic [ADDR_W-1:0]     tbl_addr [N_LOADS];
  load_op_e              tbl_op [N_LOADS];
  logic [1:0]            tbl_kind [N_LOADS];
  int                    tbl_len;

  // memory model state
  integer                seed = 32'h2c85;
  int                    cycle;
  int                    hold_until;
  int unsigned           tb_errors;
  logic [ID_W-1:0]       pend_id [$];
  logic [ADDR_W-1:0]     pend_addr [$];
  int                    pend_due [$];

  load_unit #(.NR_ENTRIES(NR_ENTRIES)) load_unit_inst (.*);

  load_checker #(.NR_ENTRIES(NR_ENTRIES)) check_inst (
    .clk_i, .rst_ni, .flush_i, .trans_id_i, .vaddr_i, .op_i, .valid_o, .trans_id_o,
    .result_o, .mem_req_o, .mem_gnt_i, .mem_id_o, .mem_rvalid_i, .mem_rid_i,
    .mem_addr_o, .mem_size_o,
    .error_count_o (check_errors),
    .outstanding_o (outstanding),
    .retired_o     (retired),
    .dropped_o     (dropped)
  );

  task automatic add_load(input load_op_e op, input int off, input logic [1:0] kind);
    logic [ADDR_W-1:0] base;
    base = 32'h1000 + 32'(tbl_len) * 32'h48;
    tbl_tid[tbl_len]  = TRANS_ID_W'(tbl_len);
    tbl_addr[tbl_len] = {base[ADDR_W-1:3], 3'(off)};
    tbl_op[tbl_len]   = op;
    tbl_kind[tbl_len] = kind;
    tbl_len++;
  endtask

  // same byte rule as the memory the unit would see
  function automatic logic [XLEN-1:0] mem_word(input logic [ADDR_W-1:0] addr);
    logic [XLEN-1:0] w;
    logic [7:0]      b;
    for (int k = 0; k < 8; k++) begin
      b = addr[7:0] + 8'(k);
      w[k*8 +: 8] = (k % 2 == 1) ? (b ^ 8'h80) : b;
    end
    return w;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // memory model
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    mem_gnt_i <= rst_ni && (($random(seed) & 3) != 0);
    if (cycle >= int'(MAX_CYCLES)) begin
      $display("timeout after %0d cycles with %0d loads outstanding", cycle, outstanding);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // a granted request gets a random response delay
  always @(negedge clk_i) begin
    if (rst_ni && mem_req_o && mem_gnt_i) begin
      pend_id.push_back(mem_id_o);
      pend_addr.push_back(mem_addr_o);
      pend_due.push_back(cycle + 1 + ($random(seed) & 7));
    end
  end

  // answer one due request, starting the search at a random place
  always @(posedge clk_i) begin : respond
    int n;
    int start;
    int pick;
    n    = pend_id.size();
    pick = -1;
    mem_rvalid_i <= 1'b0;
    if (rst_ni && cycle >= hold_until && n > 0) begin
      start = ($random(seed) & 32'h7fff) % n;
      for (int j = 0; j < n; j++) begin
        if (pick < 0 && pend_due[(start + j) % n] <= cycle) begin
          pick = (start + j) % n;
        end
      end
      if (pick >= 0) begin
        mem_rvalid_i <= 1'b1;
        mem_rid_i    <= pend_id[pick];
        mem_rdata_i  <= mem_word(pend_addr[pick]);
        pend_id.delete(pick);
        pend_addr.delete(pick);
        pend_due.delete(pick);
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    rst_ni = 1'b0;
    flush_i = 1'b0;
    valid_i = 1'b0;
    trans_id_i = '0;
    vaddr_i = '0;
    op_i = '0;
    mem_gnt_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rid_i = '0;
    mem_rdata_i = '0;
    cycle = 0;
    hold_until = 0;
    tb_errors = 0;
    tbl_len = 0;

    // every legal offset of every size and sign
    for (int off = 0; off < 8; off++) begin
      add_load(LB, off, K_PLAIN);
      add_load(LBU, off, K_PLAIN);
    end
    for (int off = 0; off < 8; off += 2) begin
      add_load(LH, off, K_PLAIN);
      add_load(LHU, off, K_PLAIN);
    end
    add_load(LW, 0, K_PLAIN);
    add_load(LWU, 0, K_PLAIN);
    add_load(LW, 4, K_PLAIN);
    add_load(LWU, 4, K_PLAIN);
    add_load(LD, 0, K_PLAIN);
    // the buffer fills up while the memory stays silent
    add_load(LD, 0, K_HOLD);
    add_load(LW, 0, K_PLAIN);
    add_load(LWU, 4, K_PLAIN);
    add_load(LH, 6, K_PLAIN);
    add_load(LB, 5, K_PLAIN);
    add_load(LHU, 2, K_PLAIN);
    add_load(LB, 1, K_FLUSH);
    add_load(LW, 4, K_PLAIN);
    add_load(LBU, 7, K_PLAIN);
    add_load(LD, 0, K_PLAIN);
    add_load(LH, 0, K_PLAIN);

    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < tbl_len; i++) begin
      if (tbl_kind[i] == K_FLUSH) begin
        @(posedge clk_i);
        valid_i <= 1'b0;
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
      end
      @(posedge clk_i);
      if (tbl_kind[i] == K_HOLD) begin
        hold_until <= cycle + HOLD_CYCLES;
      end
      valid_i    <= 1'b1;
      trans_id_i <= tbl_tid[i];
      vaddr_i    <= tbl_addr[i];
      op_i.code  <= tbl_op[i];
      // the fields stay put until the unit takes them
      do begin
        @(negedge clk_i);
      end while (!pop_ld_o);
    end
    @(posedge clk_i);
    valid_i <= 1'b0;

    // let every response come back, flushed ones included
    while (outstanding != 0 || pend_id.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (2) @(posedge clk_i);

    if (retired + dropped != N_LOADS) begin
      $display("only %0d of %0d loads came back", retired + dropped, N_LOADS);
      tb_errors++;
    end
    if (dropped == 0) begin
      $display("no load was outstanding at the flush");
      tb_errors++;
    end
    $display("errors: checker %0d, testbench %0d", check_errors, tb_errors);
    if (check_errors == 0 && tb_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== hdl/ldbuf_if.sv ====
// ----------------------------------------------------------------------
// slot allocation link between issue control and the load buffer
// ----------------------------------------------------------------------
`timescale 1ns/1ns

interface ldbuf_if #(
  parameter int unsigned NR_ENTRIES = 4
) ();
  import load_pkg::*;

  // slot id width follows the number of buffer slots
  localparam int unsigned ID_W = $clog2(NR_ENTRIES);

  // every slot holds an outstanding load
  logic            full;
  // slot that the next granted load goes into, also the memory request id
  logic [ID_W-1:0] free_id;
  // a load was granted this cycle and takes the free slot
  logic            alloc;
  // what gets stored in that slot
  ldbuf_entry_t    alloc_entry;

  // issue control side
  modport alloc_mp (
    input  full,
    input  free_id,
    output alloc,
    output alloc_entry
  );

  // buffer side
  modport store_mp (
    output full,
    output free_id,
    input  alloc,
    input  alloc_entry
  );

endinterface

// ==== hdl/load_buffer.sv ====
// ----------------------------------------------------------------------
// table of outstanding loads indexed by memory request id
// slots are booked on a grant and freed by the matching response
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module load_buffer #(
  parameter int unsigned NR_ENTRIES = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  // response side of the memory port
  input  logic                           mem_rvalid_i,
  input  logic [$clog2(NR_ENTRIES)-1:0]  mem_rid_i,
  // slot addressed by the response
  output load_pkg::ldbuf_entry_t         rd_entry_o,
  output logic                           rd_flushed_o,
  // allocation from issue control
  ldbuf_if.store_mp                      ldbuf
);
  import load_pkg::*;

  localparam int unsigned ID_W = $clog2(NR_ENTRIES);

  logic [NR_ENTRIES-1:0]    valid_d, valid_q;
  logic [NR_ENTRIES-1:0]    flushed_d, flushed_q;
  ldbuf_entry_t [NR_ENTRIES-1:0] entries_q;
  logic [ID_W-1:0]          free_q;

  // lowest numbered slot that is not in use
  function automatic logic [ID_W-1:0] first_free(input logic [NR_ENTRIES-1:0] used);
    logic [ID_W-1:0] idx;
    idx = '0;
    for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
      if (!used[i]) begin
        idx = ID_W'(i);
      end
    end
    return idx;
  endfunction

  // ----------------------------------------------------------------------
  // slot status
  // ----------------------------------------------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;

    // a flush marks every load in flight so its data is thrown away
    if (flush_i) begin
      flushed_d = '1;
    end
    // the response gives its slot back
    if (mem_rvalid_i) begin
      valid_d[mem_rid_i] = 1'b0;
    end
    // the free slot is never the one that answers, so both can happen at once
    if (ldbuf.alloc) begin
      valid_d[ldbuf.free_id]   = 1'b1;
      flushed_d[ldbuf.free_id] = flush_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      free_q    <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      // keep pointing at the same free slot until it is taken, so a
      // waiting request keeps its id when an older load answers
      if (valid_d[free_q]) begin
        free_q <= first_free(valid_d);
      end
    end
  end

  // ----------------------------------------------------------------------
  // entry storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (ldbuf.alloc) begin
      entries_q[ldbuf.free_id] <= ldbuf.alloc_entry;
    end
  end

  assign ldbuf.full    = &valid_q;
  assign ldbuf.free_id = free_q;

  // lookup is combinational so the result retires with the response
  assign rd_entry_o   = entries_q[mem_rid_i];
  assign rd_flushed_o = flushed_q[mem_rid_i];

endmodule

// ==== hdl/load_issue_ctrl.sv ====
// ----------------------------------------------------------------------
// request FSM of the load unit, presents loads on the memory port
// and keeps a request steady until the memory grants it
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module load_issue_ctrl #(
  parameter int unsigned NR_ENTRIES = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  // load request from the core
  input  logic                                 valid_i,
  input  logic [load_pkg::TRANS_ID_W-1:0]      trans_id_i,
  input  logic [load_pkg::ADDR_W-1:0]          vaddr_i,
  input  load_pkg::load_op_u                   op_i,
  output logic                                 pop_ld_o,
  // memory request side
  input  logic                                 mem_gnt_i,
  output logic                                 mem_req_o,
  output logic [load_pkg::ADDR_W-1:0]          mem_addr_o,
  output logic [1:0]                           mem_size_o,
  output logic [$clog2(NR_ENTRIES)-1:0]        mem_id_o,
  // slot allocation in the load buffer
  ldbuf_if.alloc_mp                            ldbuf
);
  import load_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    FLUSH_GAP
  } state_e;

  state_e state_d, state_q;
  logic   granted;

  // ----------------------------------------------------------------------
  // request fields
  // ----------------------------------------------------------------------
  // the core holds its fields until the pop, so they can feed the port
  // directly; the memory sees a word address and selects bytes by size
  assign mem_addr_o = {vaddr_i[ADDR_W-1:ALIGN_BITS], {ALIGN_BITS{1'b0}}};
  assign mem_size_o = op_i.fields.size;
  // the slot id stays put while a request waits, see the load buffer
  assign mem_id_o   = ldbuf.free_id;

  // ----------------------------------------------------------------------
  // request FSM
  // ----------------------------------------------------------------------
  always_comb begin
    state_d   = state_q;
    mem_req_o = 1'b0;

    case (state_q)
      IDLE: begin
        // a flush drops whatever the core offers this cycle
        if (flush_i) begin
          state_d = FLUSH_GAP;
        end else if (valid_i && !ldbuf.full) begin
          mem_req_o = 1'b1;
          // back-to-back loads stay here when granted at once
          if (!mem_gnt_i) begin
            state_d = WAIT_GNT;
          end
        end
      end

      WAIT_GNT: begin
        // once raised the request is never withdrawn, not even by a flush
        mem_req_o = 1'b1;
        if (mem_gnt_i) begin
          state_d = flush_i ? FLUSH_GAP : IDLE;
        end
      end

      FLUSH_GAP: begin
        // one quiet cycle so the core can settle its new input
        if (!flush_i) begin
          state_d = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------------------
  // grant handling
  // ----------------------------------------------------------------------
  // the grant cycle pops the core and books the load in the buffer
  assign granted  = mem_req_o & mem_gnt_i;
  assign pop_ld_o = granted;

  assign ldbuf.alloc                = granted;
  assign ldbuf.alloc_entry.trans_id = trans_id_i;
  assign ldbuf.alloc_entry.offset   = vaddr_i[ALIGN_BITS-1:0];
  assign ldbuf.alloc_entry.op       = op_i;

endmodule

// ==== hdl/load_pkg.sv ====
// ----------------------------------------------------------------------
// shared widths, load operation encoding and load buffer slot layout
// imported by every block of the load unit
// ----------------------------------------------------------------------
package load_pkg;

  // data path and memory word width
  localparam int unsigned XLEN       = 64;
  // address bits that pick a byte inside one memory word
  localparam int unsigned ALIGN_BITS = 3;
  // byte address width on the request side
  localparam int unsigned ADDR_W     = 32;
  // scoreboard transaction id width
  localparam int unsigned TRANS_ID_W = 4;

  // ----------------------------------------------------------------------
  // load operation
  // ----------------------------------------------------------------------
  // the raw codes are laid out so that bit 2 is the unsigned flag and
  // bits 1:0 are the access size, which lets the datapath read fields
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LD  = 3'b011,
    LBU = 3'b100,
    LHU = 3'b101,
    LWU = 3'b110
  } load_op_e;

  // access size, also the encoding of the memory size field
  typedef enum logic [1:0] {
    SZ_BYTE   = 2'd0,
    SZ_HALF   = 2'd1,
    SZ_WORD   = 2'd2,
    SZ_DOUBLE = 2'd3
  } load_size_e;

  typedef struct packed {
    logic       is_unsigned;
    load_size_e size;
  } load_op_fields_t;

  // one 3-bit word seen either as an opcode or as flag plus size
  typedef union packed {
    load_op_e        code;
    load_op_fields_t fields;
  } load_op_u;

  // one outstanding load, 10 bits wide
  typedef struct packed {
    logic [TRANS_ID_W-1:0] trans_id;
    logic [ALIGN_BITS-1:0] offset;
    load_op_u              op;
  } ldbuf_entry_t;

endpackage

// ==== hdl/load_result_align.sv ====
// ----------------------------------------------------------------------
// moves response data down to bit 0 and extends it per load type
// purely combinational, sits between the buffer lookup and the outputs
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module load_result_align (
  input  logic                             mem_rvalid_i,
  input  logic [load_pkg::XLEN-1:0]        mem_rdata_i,
  input  load_pkg::ldbuf_entry_t           rd_entry_i,
  input  logic                             rd_flushed_i,
  output logic                             valid_o,
  output logic [load_pkg::TRANS_ID_W-1:0]  trans_id_o,
  output logic [load_pkg::XLEN-1:0]        result_o
);
  import load_pkg::*;

  logic [XLEN-1:0]       shifted_data;
  logic [XLEN/8-1:0]     byte_sign;
  logic [ALIGN_BITS-1:0] sign_idx;
  logic                  sign_bit;

  // ----------------------------------------------------------------------
  // data path
  // ----------------------------------------------------------------------
  // right shift by the byte offset brings the loaded bytes to the bottom
  assign shifted_data = mem_rdata_i >> {rd_entry_i.offset, 3'b000};

  // top bit of every byte of the raw word, picked in parallel with the shift
  for (genvar i = 0; i < XLEN / 8; i++) begin : gen_byte_sign
    assign byte_sign[i] = mem_rdata_i[i*8+7];
  end

  // the sign lives in the highest loaded byte; only the signed codes
  // need it, the unsigned ones force it low below
  assign sign_idx = (rd_entry_i.op.code == LW) ? rd_entry_i.offset + ALIGN_BITS'(3) :
                    (rd_entry_i.op.code == LH) ? rd_entry_i.offset + ALIGN_BITS'(1) :
                                                 rd_entry_i.offset;

  assign sign_bit = !rd_entry_i.op.fields.is_unsigned & byte_sign[sign_idx];

  // fill the upper part with the sign or with zeros depending on size
  always_comb begin
    case (rd_entry_i.op.fields.size)
      SZ_BYTE: result_o = {{XLEN - 8{sign_bit}}, shifted_data[7:0]};
      SZ_HALF: result_o = {{XLEN - 16{sign_bit}}, shifted_data[15:0]};
      SZ_WORD: result_o = {{XLEN - 32{sign_bit}}, shifted_data[31:0]};
      default: result_o = shifted_data;
    endcase
  end

  // ----------------------------------------------------------------------
  // retire
  // ----------------------------------------------------------------------
  // answers to loads that were in flight at a flush are swallowed here
  assign valid_o    = mem_rvalid_i & !rd_flushed_i;
  assign trans_id_o = rd_entry_i.trans_id;

endmodule

// ==== hdl/load_unit.sv ====
// ----------------------------------------------------------------------
// load unit top level with several outstanding loads
// connects issue control, the load buffer and the result aligner
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module load_unit #(
  // number of loads that may be in flight, at least two
  parameter int unsigned NR_ENTRIES = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // load request from the core
  input  logic                             valid_i,
  input  logic [load_pkg::TRANS_ID_W-1:0]  trans_id_i,
  input  logic [load_pkg::ADDR_W-1:0]      vaddr_i,
  input  load_pkg::load_op_u               op_i,
  output logic                             pop_ld_o,
  // retired load back to the core
  output logic                             valid_o,
  output logic [load_pkg::TRANS_ID_W-1:0]  trans_id_o,
  output logic [load_pkg::XLEN-1:0]        result_o,
  // memory request
  output logic                             mem_req_o,
  input  logic                             mem_gnt_i,
  output logic [load_pkg::ADDR_W-1:0]      mem_addr_o,
  output logic [1:0]                       mem_size_o,
  output logic [$clog2(NR_ENTRIES)-1:0]    mem_id_o,
  // memory response, tagged with the request id
  input  logic                             mem_rvalid_i,
  input  logic [$clog2(NR_ENTRIES)-1:0]    mem_rid_i,
  input  logic [load_pkg::XLEN-1:0]        mem_rdata_i
);
  import load_pkg::*;

  ldbuf_entry_t rd_entry;
  logic         rd_flushed;

  ldbuf_if #(.NR_ENTRIES(NR_ENTRIES)) ldbuf ();

  // ----------------------------------------------------------------------
  // issue path
  // ----------------------------------------------------------------------
  load_issue_ctrl #(
    .NR_ENTRIES (NR_ENTRIES)
  ) u_issue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .valid_i    (valid_i),
    .trans_id_i (trans_id_i),
    .vaddr_i    (vaddr_i),
    .op_i       (op_i),
    .pop_ld_o   (pop_ld_o),
    .mem_gnt_i  (mem_gnt_i),
    .mem_req_o  (mem_req_o),
    .mem_addr_o (mem_addr_o),
    .mem_size_o (mem_size_o),
    .mem_id_o   (mem_id_o),
    .ldbuf      (ldbuf.alloc_mp)
  );

  // ----------------------------------------------------------------------
  // outstanding loads and response path
  // ----------------------------------------------------------------------
  load_buffer #(
    .NR_ENTRIES (NR_ENTRIES)
  ) u_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rid_i    (mem_rid_i),
    .rd_entry_o   (rd_entry),
    .rd_flushed_o (rd_flushed),
    .ldbuf        (ldbuf.store_mp)
  );

  // response data goes out in the cycle it arrives
  load_result_align u_align (
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .rd_entry_i   (rd_entry),
    .rd_flushed_i (rd_flushed),
    .valid_o      (valid_o),
    .trans_id_o   (trans_id_o),
    .result_o     (result_o)
  );

endmodule

// ==== vlog.f ====
hdl/load_pkg.sv
hdl/ldbuf_if.sv
hdl/load_issue_ctrl.sv
hdl/load_buffer.sv
hdl/load_result_align.sv
hdl/load_unit.sv
dv/load_checker.sv
dv/load_unit_props.sv
dv/tb_load_unit.sv
